// ==== src/rxDmaCtrl_config.svh ====
`ifndef RX_DMA_CTRL_CONFIG_SVH
`define RX_DMA_CTRL_CONFIG_SVH

// Register word addresses
`define RX_REG_CTRL     2'd0
`define RX_REG_HEADPTR  2'd1
`define RX_REG_STATUS   2'd2
`define RX_REG_STATPTR  2'd3

// Control register bits
`define RX_CTRL_NEWTAIL_BIT  0
`define RX_CTRL_NEWHEAD_BIT  1
`define RX_CTRL_SOFTRST_BIT  2

// Status register flags, state field sits in bits 3 to 0
`define RX_STAT_ERR_BIT   4
`define RX_STAT_DEAD_BIT  5

// Low pointer bits that must be zero for a valid pointer
`define RX_PTR_ALIGN_BITS 2

`endif

// ==== src/rxDmaPkg.sv ====
`default_nettype none

package rxDmaPkg;

  // Byte address for head, status and next descriptor pointers
  typedef logic [31:0] rxPtrT;

  // Register word address on the Wishbone side
  typedef logic [1:0] rxRegAddrT;

  // Wishbone data word
  typedef logic [31:0] rxDataT;

  // Channel state, one-hot
  // Also returned as the state field of the status register
  typedef enum logic [3:0] {
    HALTED  = 4'd1,
    PASSIVE = 4'd2,
    ACTIVE  = 4'd4,
    DEAD    = 4'd8
  } rxPcStateT;

  // List processor sequencer
  typedef enum logic {
    LP_IDLE      = 1'b0,
    LP_RECEIVING = 1'b1
  } rxLpStateT;

endpackage

`default_nettype wire

// ==== src/rxDmaIf.sv ====
`timescale 1ns/1ps
`default_nettype none

//////////////////////////////////////////////////////////////////////
// Register block to channel control
//////////////////////////////////////////////////////////////////////
interface rxCsIf
  import rxDmaPkg::*;
();
  // Driven by the register block
  logic      newTail;
  logic      newHead;
  rxPtrT     headPtr;
  // Active low, one cycle wide
  logic      softRst_n;

  // Driven by the primary controller
  logic      rstNewTail;
  logic      rstNewHead;
  rxPtrT     statusPtr;
  logic      newHeadErr;
  logic      dmaDead;
  rxPcStateT pcState;

  modport csReg (
    output newTail, newHead, headPtr, softRst_n,
    input  rstNewTail, rstNewHead, statusPtr, newHeadErr, dmaDead, pcState
  );

  modport primCtrl (
    input  newTail, newHead, headPtr, softRst_n,
    output rstNewTail, rstNewHead, statusPtr, newHeadErr, dmaDead, pcState
  );

  // List processor only follows the channel state
  modport listProc (
    input pcState, softRst_n
  );
endinterface

//////////////////////////////////////////////////////////////////////
// List processor triggers into the primary controller
//////////////////////////////////////////////////////////////////////
interface rxTrigIf
  import rxDmaPkg::*;
();
  // All one-cycle pulses
  logic  trigActive;
  logic  trigPassive;
  logic  trigHalt;
  logic  trigDead;
  logic  updStaPtr;
  // Qualified by updStaPtr
  rxPtrT nxtDescPtr;

  modport lp (
    output trigActive, trigPassive, trigHalt, trigDead, updStaPtr, nxtDescPtr
  );

  modport pc (
    input trigActive, trigPassive, trigHalt, trigDead, updStaPtr, nxtDescPtr
  );
endinterface

`default_nettype wire

// ==== src/rxCsReg.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rxDmaCtrl_config.svh"

module rxCsReg
  import rxDmaPkg::*;
(
  input  logic      macPIRxClk,
  input  logic      macPIRxClkHardRst_n,
  // Wishbone classic slave
  input  logic      wbCyc,
  input  logic      wbStb,
  input  logic      wbWe,
  input  rxRegAddrT wbAdr,
  input  rxDataT    wbDatIn,
  output rxDataT    wbDatOut,
  output logic      wbAck,
  // Interrupt towards the host
  output logic      irq,
  rxCsIf.csReg      cs
);

  // New transfer seen, ack not yet given
  logic   access;
  logic   wrEn;
  logic   ctrlWr;
  logic   newTailQ;
  logic   newHeadQ;
  rxPtrT  headPtrQ;
  // High for the cycle after a soft reset write
  logic   softRstQ;
  // Sticky, set by the dead pulse
  logic   deadFlagQ;
  rxDataT rdData;

  //////////////////////////////////////////////////////////////////////
  // Bus decode
  //////////////////////////////////////////////////////////////////////
  assign access = wbCyc && wbStb && !wbAck;
  assign wrEn   = access && wbWe;
  assign ctrlWr = wrEn && (wbAdr == `RX_REG_CTRL);

  // Single-cycle ack, no second ack while stb is held
  always_ff @(posedge macPIRxClk or negedge macPIRxClkHardRst_n)
  begin
    if (!macPIRxClkHardRst_n)
      wbAck <= 1'b0;
    else
      wbAck <= access;
  end

  // Read mux
  always_comb
  begin
    rdData = '0;
    case (wbAdr)
      `RX_REG_CTRL:
      begin
        // Soft reset bit clears itself, reads as zero
        rdData[`RX_CTRL_NEWTAIL_BIT] = newTailQ;
        rdData[`RX_CTRL_NEWHEAD_BIT] = newHeadQ;
      end
      `RX_REG_HEADPTR:
        rdData = headPtrQ;
      `RX_REG_STATUS:
      begin
        rdData[3:0]               = cs.pcState;
        rdData[`RX_STAT_ERR_BIT]  = cs.newHeadErr;
        rdData[`RX_STAT_DEAD_BIT] = deadFlagQ;
      end
      `RX_REG_STATPTR:
        rdData = cs.statusPtr;
    endcase
  end

  // Read data captured with the ack edge
  always_ff @(posedge macPIRxClk)
  begin
    if (access)
      wbDatOut <= rdData;
  end

  //////////////////////////////////////////////////////////////////////
  // Command bits
  //////////////////////////////////////////////////////////////////////
  // Write-1 sets, clear pulse or soft reset clears
  // A software set in the same cycle wins
  always_ff @(posedge macPIRxClk or negedge macPIRxClkHardRst_n)
  begin
    if (!macPIRxClkHardRst_n)
    begin
      newTailQ <= 1'b0;
      newHeadQ <= 1'b0;
    end
    else
    begin
      if (ctrlWr && wbDatIn[`RX_CTRL_NEWTAIL_BIT])
        newTailQ <= 1'b1;
      else if (cs.rstNewTail || softRstQ)
        newTailQ <= 1'b0;

      if (ctrlWr && wbDatIn[`RX_CTRL_NEWHEAD_BIT])
        newHeadQ <= 1'b1;
      else if (cs.rstNewHead || softRstQ)
        newHeadQ <= 1'b0;
    end
  end

  // Queue head pointer, kept across soft reset
  always_ff @(posedge macPIRxClk or negedge macPIRxClkHardRst_n)
  begin
    if (!macPIRxClkHardRst_n)
      headPtrQ <= '0;
    else if (wrEn && (wbAdr == `RX_REG_HEADPTR))
      headPtrQ <= wbDatIn;
  end

  //////////////////////////////////////////////////////////////////////
  // Soft reset and interrupt
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge macPIRxClk or negedge macPIRxClkHardRst_n)
  begin
    if (!macPIRxClkHardRst_n)
    begin
      softRstQ  <= 1'b0;
      deadFlagQ <= 1'b0;
    end
    else
    begin
      softRstQ <= ctrlWr && wbDatIn[`RX_CTRL_SOFTRST_BIT];
      if (softRstQ)
        deadFlagQ <= 1'b0;
      else if (cs.dmaDead)
        deadFlagQ <= 1'b1;
    end
  end

  // Level interrupt while any flag is pending
  assign irq = cs.newHeadErr || deadFlagQ;

  assign cs.newTail   = newTailQ;
  assign cs.newHead   = newHeadQ;
  assign cs.headPtr   = headPtrQ;
  assign cs.softRst_n = !softRstQ;

endmodule

`default_nettype wire

// ==== src/rxPrimCtrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rxDmaCtrl_config.svh"

module rxPrimCtrl
  import rxDmaPkg::*;
(
  input  logic    macPIRxClk,
  input  logic    macPIRxClkHardRst_n,
  rxCsIf.primCtrl cs,
  rxTrigIf.pc     trig
);

  rxPcStateT state;
  rxPcStateT nextState;
  logic      headPtrValid;
  // New head taken in HALTED with a good pointer
  logic      acceptHead;
  // New head in HALTED with a bad pointer and no tail pending
  logic      badHead;
  rxPtrT     statusPtrQ;
  logic      newHeadErrQ;
  logic      dmaDeadQ;

  // Aligned and non-zero
  assign headPtrValid = (cs.headPtr[`RX_PTR_ALIGN_BITS-1:0] == '0) &&
                        (cs.headPtr != '0);

  assign acceptHead = (state == HALTED) && cs.newHead && headPtrValid;
  // newTail has priority in HALTED, so no error while it is pending
  assign badHead    = (state == HALTED) && cs.newHead && !headPtrValid && !cs.newTail;

  //////////////////////////////////////////////////////////////////////
  // Channel FSM
  //////////////////////////////////////////////////////////////////////
  always_comb
  begin
    nextState = state;
    case (state)
      HALTED:
      begin
        // Software has chained descriptors
        if (cs.newTail || acceptHead)
          nextState = PASSIVE;
        else if (badHead)
          nextState = DEAD;
      end
      PASSIVE:
      begin
        // New head restarts from HALTED to reload the pointer
        if (cs.newHead)
          nextState = HALTED;
        else if (trig.trigActive)
          nextState = ACTIVE;
      end
      ACTIVE:
      begin
        if (trig.trigDead)
          nextState = DEAD;
        else if (trig.trigHalt || (trig.updStaPtr && cs.newHead))
          nextState = HALTED;
        else if (trig.trigPassive)
          nextState = PASSIVE;
      end
      DEAD:
        // Left only through soft reset
        nextState = DEAD;
      default:
        nextState = HALTED;
    endcase
  end

  always_ff @(posedge macPIRxClk or negedge macPIRxClkHardRst_n)
  begin
    if (!macPIRxClkHardRst_n)
      state <= HALTED;
    else if (!cs.softRst_n)
      state <= HALTED;
    else
      state <= nextState;
  end

  //////////////////////////////////////////////////////////////////////
  // Status pointer and error flags
  //////////////////////////////////////////////////////////////////////
  // Head pointer on a new queue, next descriptor after each frame
  always_ff @(posedge macPIRxClk or negedge macPIRxClkHardRst_n)
  begin
    if (!macPIRxClkHardRst_n)
      statusPtrQ <= '0;
    else if (!cs.softRst_n)
      statusPtrQ <= '0;
    else if (acceptHead)
      statusPtrQ <= cs.headPtr;
    else if ((state == ACTIVE) && trig.updStaPtr)
      statusPtrQ <= trig.nxtDescPtr;
  end

  always_ff @(posedge macPIRxClk or negedge macPIRxClkHardRst_n)
  begin
    if (!macPIRxClkHardRst_n)
    begin
      newHeadErrQ <= 1'b0;
      dmaDeadQ    <= 1'b0;
    end
    else if (!cs.softRst_n)
    begin
      newHeadErrQ <= 1'b0;
      dmaDeadQ    <= 1'b0;
    end
    else
    begin
      // Sticky until soft reset
      if (badHead)
        newHeadErrQ <= 1'b1;
      // Pulse on each entry into DEAD
      dmaDeadQ <= badHead || ((state == ACTIVE) && trig.trigDead);
    end
  end

  // Bit clears, tail in ACTIVE only once the pointer has moved on
  assign cs.rstNewTail = cs.newTail &&
                         ((state == HALTED) || (state == PASSIVE) ||
                          ((state == ACTIVE) && trig.updStaPtr));
  assign cs.rstNewHead = acceptHead;

  assign cs.statusPtr  = statusPtrQ;
  assign cs.newHeadErr = newHeadErrQ;
  assign cs.dmaDead    = dmaDeadQ;
  assign cs.pcState    = state;

endmodule

`default_nettype wire

// ==== src/rxListProc.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rxDmaCtrl_config.svh"

module rxListProc
  import rxDmaPkg::*;
(
  input  logic    macPIRxClk,
  input  logic    macPIRxClkHardRst_n,
  // Frame side
  input  logic    rxFrameReq,
  input  logic    rxFrameDone,
  input  logic    rxBusErr,
  input  rxPtrT   descNxtPtr,
  output logic    rxFrameAck,
  rxCsIf.listProc cs,
  rxTrigIf.lp     trig
);

  rxLpStateT lpState;
  logic      nxtPtrValid;
  // Channel left ACTIVE, ignoring the cycle right after trigActive
  logic      lostActive;

  assign nxtPtrValid = (descNxtPtr[`RX_PTR_ALIGN_BITS-1:0] == '0) &&
                       (descNxtPtr != '0);

  assign lostActive = (cs.pcState != ACTIVE) && !trig.trigActive;

  //////////////////////////////////////////////////////////////////////
  // Frame sequencer
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge macPIRxClk or negedge macPIRxClkHardRst_n)
  begin
    if (!macPIRxClkHardRst_n)
    begin
      lpState          <= LP_IDLE;
      rxFrameAck       <= 1'b0;
      trig.trigActive  <= 1'b0;
      trig.trigPassive <= 1'b0;
      trig.trigHalt    <= 1'b0;
      trig.trigDead    <= 1'b0;
      trig.updStaPtr   <= 1'b0;
    end
    else
    begin
      // Pulses by default
      rxFrameAck       <= 1'b0;
      trig.trigActive  <= 1'b0;
      trig.trigPassive <= 1'b0;
      trig.trigHalt    <= 1'b0;
      trig.trigDead    <= 1'b0;
      trig.updStaPtr   <= 1'b0;
      if (!cs.softRst_n)
        lpState <= LP_IDLE;
      else
      begin
        case (lpState)
          LP_IDLE:
          begin
            // Requests outside PASSIVE wait
            if (rxFrameReq && (cs.pcState == PASSIVE))
            begin
              rxFrameAck      <= 1'b1;
              trig.trigActive <= 1'b1;
              lpState         <= LP_RECEIVING;
            end
          end
          LP_RECEIVING:
          begin
            if (lostActive)
              lpState <= LP_IDLE;
            else if (rxBusErr)
            begin
              trig.trigDead <= 1'b1;
              lpState       <= LP_IDLE;
            end
            else if (rxFrameDone)
            begin
              // Good pointer continues the list, a bad one halts
              trig.updStaPtr   <= nxtPtrValid;
              trig.trigPassive <= nxtPtrValid;
              trig.trigHalt    <= !nxtPtrValid;
              lpState          <= LP_IDLE;
            end
          end
          default:
            lpState <= LP_IDLE;
        endcase
      end
    end
  end

  // Next pointer travels alongside updStaPtr
  always_ff @(posedge macPIRxClk)
  begin
    if (rxFrameDone)
      trig.nxtDescPtr <= descNxtPtr;
  end

endmodule

`default_nettype wire

// ==== src/rxDmaCtrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module rxDmaCtrl
  import rxDmaPkg::*;
(
  input  logic      macPIRxClk,
  input  logic      macPIRxClkHardRst_n,
  // Wishbone classic slave
  input  logic      wbCyc,
  input  logic      wbStb,
  input  logic      wbWe,
  input  rxRegAddrT wbAdr,
  input  rxDataT    wbDatIn,
  output rxDataT    wbDatOut,
  output logic      wbAck,
  // Frame side
  input  logic      rxFrameReq,
  output logic      rxFrameAck,
  input  logic      rxFrameDone,
  input  rxPtrT     descNxtPtr,
  input  logic      rxBusErr,
  // Interrupt
  output logic      rxDmaIrq
);

  rxCsIf   csIf ();
  rxTrigIf trigIf ();

  // Software registers
  rxCsReg uCsReg (
    .macPIRxClk          (macPIRxClk),
    .macPIRxClkHardRst_n (macPIRxClkHardRst_n),
    .wbCyc               (wbCyc),
    .wbStb               (wbStb),
    .wbWe                (wbWe),
    .wbAdr               (wbAdr),
    .wbDatIn             (wbDatIn),
    .wbDatOut            (wbDatOut),
    .wbAck               (wbAck),
    .irq                 (rxDmaIrq),
    .cs                  (csIf.csReg)
  );

  // Channel state
  rxPrimCtrl uPrimCtrl (
    .macPIRxClk          (macPIRxClk),
    .macPIRxClkHardRst_n (macPIRxClkHardRst_n),
    .cs                  (csIf.primCtrl),
    .trig                (trigIf.pc)
  );

  // Frame events to triggers
  rxListProc uListProc (
    .macPIRxClk          (macPIRxClk),
    .macPIRxClkHardRst_n (macPIRxClkHardRst_n),
    .rxFrameReq          (rxFrameReq),
    .rxFrameDone         (rxFrameDone),
    .rxBusErr            (rxBusErr),
    .descNxtPtr          (descNxtPtr),
    .rxFrameAck          (rxFrameAck),
    .cs                  (csIf.listProc),
    .trig                (trigIf.lp)
  );

endmodule

`default_nettype wire

// ==== tests/rxDmaCtrlTb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rxDmaCtrl_config.svh"

module rxDmaCtrlTb;

  // Channel states as the status register returns them
  localparam logic [3:0] ST_HALTED  = 4'h1;
  localparam logic [3:0] ST_PASSIVE = 4'h2;
  localparam logic [3:0] ST_ACTIVE  = 4'h4;
  localparam logic [3:0] ST_DEAD    = 4'h8;
  // Generous bound on the length of the whole sequence
  localparam int CYCLE_LIMIT = 4000;

  logic        macPIRxClk;
  logic        macPIRxClkHardRst_n;
  logic        wbCyc;
  logic        wbStb;
  logic        wbWe;
  logic [1:0]  wbAdr;
  logic [31:0] wbDatIn;
  logic [31:0] wbDatOut;
  logic        wbAck;
  logic        rxFrameReq;
  logic        rxFrameAck;
  logic        rxFrameDone;
  logic [31:0] descNxtPtr;
  logic        rxBusErr;
  logic        rxDmaIrq;

  int          errorCount;
  int          checkCount;
  int          cycleCount;
  int          wbAckCount;
  int          wbXferCount;
  int          frameAckCount;
  logic [31:0] rngState;
  // Reference model of the channel
  logic [3:0]  expState;
  logic        expErr;
  logic        expDead;
  logic [31:0] expStatPtr;
  // Irq may rise only while armed and fall only around a soft reset
  logic        irqArmed;
  logic        softRstPending;

  rxDmaCtrl dut (
    .macPIRxClk          (macPIRxClk),
    .macPIRxClkHardRst_n (macPIRxClkHardRst_n),
    .wbCyc               (wbCyc),
    .wbStb               (wbStb),
    .wbWe                (wbWe),
    .wbAdr               (wbAdr),
    .wbDatIn             (wbDatIn),
    .wbDatOut            (wbDatOut),
    .wbAck               (wbAck),
    .rxFrameReq          (rxFrameReq),
    .rxFrameAck          (rxFrameAck),
    .rxFrameDone         (rxFrameDone),
    .descNxtPtr          (descNxtPtr),
    .rxBusErr            (rxBusErr),
    .rxDmaIrq            (rxDmaIrq)
  );

  initial
  begin
    macPIRxClk = 1'b0;
    forever #20 macPIRxClk = ~macPIRxClk;
  end

  // Handshake counters sample the value before the edge updates it
  always @(posedge macPIRxClk)
  begin
    if (wbAck === 1'b1)
      wbAckCount++;
    if (rxFrameAck === 1'b1)
      frameAckCount++;
  end

  // Watchdog
  initial
  begin
    cycleCount = 0;
    while (cycleCount < CYCLE_LIMIT)
    begin
      @(posedge macPIRxClk);
      cycleCount++;
    end
    $display("Timeout: the sequence did not finish within %0d cycles, %0d errors in %0d checks",
             CYCLE_LIMIT, errorCount, checkCount);
    $display("Something failed");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // Protocol assertions
  //////////////////////////////////////////////////////////////////////
  ackOnePulse: assert property (@(posedge macPIRxClk) disable iff (!macPIRxClkHardRst_n)
    wbAck |=> !wbAck)
  else
  begin
    errorCount++;
    $display("Wishbone ack stayed high for more than one cycle at %0t", $time);
  end

  ackAfterReq: assert property (@(posedge macPIRxClk) disable iff (!macPIRxClkHardRst_n)
    wbAck |-> $past(wbCyc && wbStb))
  else
  begin
    errorCount++;
    $display("Wishbone ack came without a request at %0t", $time);
  end

  frameAckPulse: assert property (@(posedge macPIRxClk) disable iff (!macPIRxClkHardRst_n)
    rxFrameAck |=> !rxFrameAck)
  else
  begin
    errorCount++;
    $display("Frame acknowledge lasted more than one cycle at %0t", $time);
  end

  frameAckAfterReq: assert property (@(posedge macPIRxClk) disable iff (!macPIRxClkHardRst_n)
    rxFrameAck |-> $past(rxFrameReq))
  else
  begin
    errorCount++;
    $display("Frame acknowledge came without a request at %0t", $time);
  end

  irqOnlyWhenArmed: assert property (@(posedge macPIRxClk) disable iff (!macPIRxClkHardRst_n)
    rxDmaIrq |-> irqArmed)
  else
  begin
    errorCount++;
    $display("Interrupt raised with no error or dead condition at %0t", $time);
  end

  irqHeldToSoftRst: assert property (@(posedge macPIRxClk) disable iff (!macPIRxClkHardRst_n)
    $fell(rxDmaIrq) |-> softRstPending)
  else
  begin
    errorCount++;
    $display("Interrupt dropped without a soft reset at %0t", $time);
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Aligned and non-zero
  function automatic logic isValidPtr(input logic [31:0] p);
    return (p[1:0] == 2'b00) && (p != 32'h0);
  endfunction

  function automatic logic [31:0] makeValidPtr(input logic [31:0] r);
    logic [31:0] p;
    p = {r[31:2], 2'b00};
    if (p == 32'h0)
      p = 32'h0000_0100;
    return p;
  endfunction

  // Either zero or misaligned
  function automatic logic [31:0] makeBadPtr(input logic [31:0] r);
    return r[7] ? 32'h0 : (r | 32'h1);
  endfunction

  function automatic logic [31:0] statusWord(input logic [3:0] st, input logic err,
                                             input logic dead);
    logic [31:0] w;
    w                    = 32'h0;
    w[3:0]               = st;
    w[`RX_STAT_ERR_BIT]  = err;
    w[`RX_STAT_DEAD_BIT] = dead;
    return w;
  endfunction

  task automatic checkEqual(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    checkCount++;
    assert (got === exp)
    else
    begin
      errorCount++;
      $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic waitCycles(input int n);
    repeat (n) @(posedge macPIRxClk);
  endtask

  // One classic transfer held until ack
  task automatic busCycle(input logic we, input logic [1:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata);
    int waitCnt;
    waitCnt = 0;
    @(posedge macPIRxClk);
    wbCyc   <= 1'b1;
    wbStb   <= 1'b1;
    wbWe    <= we;
    wbAdr   <= addr;
    wbDatIn <= wdata;
    wbXferCount++;
    @(negedge macPIRxClk);
    while ((wbAck !== 1'b1) && (waitCnt < 16))
    begin
      @(negedge macPIRxClk);
      waitCnt++;
    end
    assert (wbAck === 1'b1)
    else
    begin
      errorCount++;
      $display("Wishbone transfer to register %0d got no ack", addr);
    end
    rdata = wbDatOut;
    @(posedge macPIRxClk);
    wbCyc <= 1'b0;
    wbStb <= 1'b0;
    wbWe  <= 1'b0;
  endtask

  task automatic writeReg(input logic [1:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    busCycle(1'b1, addr, data, unused);
  endtask

  task automatic readReg(input logic [1:0] addr, output logic [31:0] data);
    busCycle(1'b0, addr, 32'h0, data);
  endtask

  task automatic checkReg(input logic [1:0] addr, input string name, input logic [31:0] exp);
    logic [31:0] val;
    readReg(addr, val);
    checkEqual(name, val, exp);
  endtask

  // State moves a cycle after a trigger and the dead flag one cycle later
  task automatic checkModel();
    waitCycles(2);
    checkReg(`RX_REG_STATUS, "STATUS", statusWord(expState, expErr, expDead));
    checkReg(`RX_REG_STATPTR, "STATPTR", expStatPtr);
  endtask

  // From HALTED only
  task automatic applyNewHead(input logic [31:0] ptr);
    writeReg(`RX_REG_HEADPTR, ptr);
    writeReg(`RX_REG_CTRL, 32'h1 << `RX_CTRL_NEWHEAD_BIT);
    if (isValidPtr(ptr))
    begin
      expState   = ST_PASSIVE;
      expStatPtr = ptr;
    end
    else
    begin
      // Entry into DEAD raises the dead flag as well
      expState = ST_DEAD;
      expErr   = 1'b1;
      expDead  = 1'b1;
    end
  endtask

  task automatic softReset();
    softRstPending = 1'b1;
    writeReg(`RX_REG_CTRL, 32'h1 << `RX_CTRL_SOFTRST_BIT);
    expState   = ST_HALTED;
    expStatPtr = 32'h0;
    expErr     = 1'b0;
    expDead    = 1'b0;
  endtask

  task automatic raiseFrameReq();
    @(posedge macPIRxClk);
    rxFrameReq <= 1'b1;
  endtask

  task automatic waitFrameAck(input int startCount);
    int waitCnt;
    waitCnt = 0;
    while ((frameAckCount == startCount) && (waitCnt < 32))
    begin
      @(negedge macPIRxClk);
      waitCnt++;
    end
    assert (frameAckCount != startCount)
    else
    begin
      errorCount++;
      $display("Frame request in PASSIVE got no acknowledge at %0t", $time);
    end
    @(posedge macPIRxClk);
    rxFrameReq <= 1'b0;
    expState = ST_ACTIVE;
  endtask

  // PASSIVE to ACTIVE through a frame request
  task automatic startFrame();
    int c0;
    c0 = frameAckCount;
    raiseFrameReq();
    waitFrameAck(c0);
    checkModel();
  endtask

  // Done event while ACTIVE
  task automatic endFrame(input logic [31:0] ptr);
    @(posedge macPIRxClk);
    rxFrameDone <= 1'b1;
    descNxtPtr  <= ptr;
    @(posedge macPIRxClk);
    rxFrameDone <= 1'b0;
    if (isValidPtr(ptr))
    begin
      expState   = ST_PASSIVE;
      expStatPtr = ptr;
    end
    else
      expState = ST_HALTED;
  endtask

  task automatic injectBusErr();
    @(posedge macPIRxClk);
    rxBusErr <= 1'b1;
    @(posedge macPIRxClk);
    rxBusErr <= 1'b0;
    expState = ST_DEAD;
    expDead  = 1'b1;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Sequence
  //////////////////////////////////////////////////////////////////////
  initial
  begin : mainSeq
    int c0;
    errorCount          = 0;
    checkCount          = 0;
    wbAckCount          = 0;
    wbXferCount         = 0;
    frameAckCount       = 0;
    rngState            = 32'h43d7_c534;
    expState            = ST_HALTED;
    expErr              = 1'b0;
    expDead             = 1'b0;
    expStatPtr          = 32'h0;
    irqArmed            = 1'b0;
    softRstPending      = 1'b0;
    macPIRxClkHardRst_n = 1'b0;
    wbCyc               = 1'b0;
    wbStb               = 1'b0;
    wbWe                = 1'b0;
    wbAdr               = 2'd0;
    wbDatIn             = 32'h0;
    rxFrameReq          = 1'b0;
    rxFrameDone         = 1'b0;
    descNxtPtr          = 32'h0;
    rxBusErr            = 1'b0;
    waitCycles(8);
    macPIRxClkHardRst_n <= 1'b1;

    // Reset values and head pointer read-back
    @(negedge macPIRxClk);
    checkEqual("wbAck", wbAck, 32'h0);
    checkEqual("rxFrameAck", rxFrameAck, 32'h0);
    checkEqual("rxDmaIrq", rxDmaIrq, 32'h0);
    checkModel();
    checkReg(`RX_REG_CTRL, "CTRL", 32'h0);
    repeat (4)
    begin
      rngState = xorshift32(rngState);
      writeReg(`RX_REG_HEADPTR, rngState);
      checkReg(`RX_REG_HEADPTR, "HEADPTR", rngState);
    end

    // New head with a good pointer
    rngState = xorshift32(rngState);
    applyNewHead(makeValidPtr(rngState));
    checkModel();
    checkReg(`RX_REG_CTRL, "CTRL", 32'h0);

    // Frames with a good and then a bad next pointer
    startFrame();
    rngState = xorshift32(rngState);
    endFrame(makeValidPtr(rngState));
    checkModel();
    startFrame();
    rngState = xorshift32(rngState);
    endFrame(makeBadPtr(rngState));
    checkModel();

    // New tail from HALTED and then halt again
    writeReg(`RX_REG_CTRL, 32'h1 << `RX_CTRL_NEWTAIL_BIT);
    expState = ST_PASSIVE;
    checkModel();
    checkReg(`RX_REG_CTRL, "CTRL", 32'h0);
    startFrame();
    endFrame(32'h0);
    checkModel();

    // Request while HALTED waits for PASSIVE
    c0 = frameAckCount;
    raiseFrameReq();
    waitCycles(10);
    checkEqual("rxFrameAck count", frameAckCount, c0);
    writeReg(`RX_REG_CTRL, 32'h1 << `RX_CTRL_NEWTAIL_BIT);
    waitFrameAck(c0);
    checkModel();
    rngState = xorshift32(rngState);
    endFrame(makeBadPtr(rngState));
    checkModel();

    // Bad head pointer kills the channel
    irqArmed = 1'b1;
    rngState = xorshift32(rngState);
    applyNewHead(makeBadPtr(rngState));
    checkModel();
    checkEqual("rxDmaIrq", rxDmaIrq, 32'h1);
    c0 = frameAckCount;
    raiseFrameReq();
    waitCycles(10);
    checkEqual("rxFrameAck count", frameAckCount, c0);
    softReset();
    @(posedge macPIRxClk);
    rxFrameReq <= 1'b0;
    checkModel();
    checkReg(`RX_REG_CTRL, "CTRL", 32'h0);
    checkEqual("rxFrameAck count", frameAckCount, c0);
    checkEqual("rxDmaIrq", rxDmaIrq, 32'h0);
    irqArmed       = 1'b0;
    softRstPending = 1'b0;

    // Bus error while receiving
    rngState = xorshift32(rngState);
    applyNewHead(makeValidPtr(rngState));
    checkModel();
    startFrame();
    irqArmed = 1'b1;
    injectBusErr();
    checkModel();
    checkEqual("rxDmaIrq", rxDmaIrq, 32'h1);
    softReset();
    checkModel();
    checkEqual("rxDmaIrq", rxDmaIrq, 32'h0);
    irqArmed       = 1'b0;
    softRstPending = 1'b0;

    // One ack for each transfer
    waitCycles(2);
    checkEqual("wbAck count", wbAckCount, wbXferCount);

    $display("Run finished: %0d errors in %0d checks", errorCount, checkCount);
    if (errorCount == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== rxDmaCtrl.f ====
+incdir+src
src/rxDmaPkg.sv
src/rxDmaIf.sv
src/rxCsReg.sv
src/rxPrimCtrl.sv
src/rxListProc.sv
src/rxDmaCtrl.sv
tests/rxDmaCtrlTb.sv
